// File: rx_intf.f
+incdir+design
design/rx_intf_pkg.sv
design/byte_to_word.sv
design/rx_word_assemble.sv
design/rx_word_fifo.sv
design/rx_pkt_ctrl.sv
design/rx_intf.sv
test/tb_rx_intf.sv

// File: test/tb_rx_intf.sv
// model assumes a 16-word FIFO, the fixed header/status layout and no packet of length 0
`timescale 1ns/1ps

module tb_rx_intf;

  localparam int NUM_ROWS   = 12;
  localparam int FIFO_WORDS = 16;
  localparam int CLK_NS     = 8;

  typedef struct packed {
    logic [15:0] len;
    logic [7:0]  rate;
    logic [63:0] tsf;
    logic        fcs;
    logic        hdr_valid;
    logic        stall;
  } row_t;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          pkt_header_valid_strobe;
  logic          pkt_header_valid;
  logic [7:0]    pkt_rate;
  logic [15:0]   pkt_len;
  logic [63:0]   tsf_runtime_val;
  logic          byte_in_strobe;
  logic [7:0]    byte_in;
  logic          fcs_in_strobe;
  logic          fcs_ok;
  logic          m_axis_tvalid;
  logic [63:0]   m_axis_tdata;
  logic          m_axis_tlast;
  logic          m_axis_tready;
  logic          rx_pkt_intr;

  row_t          tbl [NUM_ROWS];
  logic [64:0]   exp_q [$];
  logic [64:0]   exp_word;
  logic [1023:0] ready_pat;
  logic          ready_nxt;
  logic          stall_now = 1'b0;
  logic          drain = 1'b0;
  logic          held = 1'b0;
  logic [64:0]   held_data;
  logic [15:0]   sn = '0;
  int            cyc = 0;
  int            checks = 0;
  int            errors = 0;
  int            words = 0;
  int            intr_count = 0;
  int            accepted = 0;

  rx_intf u_dut (.*);

  always #(CLK_NS / 2) clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_true(input logic ok, input string msg);
    checks++;
    assert (ok)
    else
    begin
      errors++;
      $display("ERROR @%0t: %s", $time, msg);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      next_cycle();
  endtask

  // drives one packet and queues the words it should produce
  task automatic send_packet(input row_t r, output string outcome);
    logic [63:0] acc;
    logic [63:0] word;
    logic [7:0]  b;
    int          lane;
    int          need;
    logic        take;
    acc  = '0;
    lane = 0;
    need = 2 + r.len / 8 + ((r.len % 8 != 0) ? 1 : 0);
    take = r.hdr_valid && (need <= FIFO_WORDS - exp_q.size());
    outcome = !r.hdr_valid ? "ignored" : (take ? "queued" : "dropped");
    if (take)
    begin
      word = '0;
      word[15:0]  = r.len;
      word[23:16] = r.rate;
      word[47:32] = sn;
      word[63:48] = r.tsf[15:0];
      exp_q.push_back({1'b0, word});
      accepted++;
    end
    pkt_header_valid_strobe = 1'b1;
    pkt_header_valid        = r.hdr_valid;
    pkt_len                 = r.len;
    pkt_rate                = r.rate;
    tsf_runtime_val         = r.tsf;
    next_cycle();
    pkt_header_valid_strobe = 1'b0;
    for (int k = 0; k < r.len; k++)
    begin
      // now and then an idle cycle between bytes
      if ($urandom_range(0, 3) == 0)
      begin
        byte_in_strobe = 1'b0;
        next_cycle();
      end
      b = 8'($urandom_range(0, 255));
      byte_in_strobe = 1'b1;
      byte_in        = b;
      acc[lane*8 +: 8] = b;
      lane++;
      if (lane == 8)
      begin
        if (take)
          exp_q.push_back({1'b0, acc});
        acc  = '0;
        lane = 0;
      end
      next_cycle();
    end
    byte_in_strobe = 1'b0;
    fcs_in_strobe  = 1'b1;
    fcs_ok         = r.fcs;
    if (take)
    begin
      // leftover bytes with the upper lanes left zero
      if (lane != 0)
        exp_q.push_back({1'b0, acc});
      word = '0;
      word[0]     = r.fcs;
      word[31:16] = r.len;
      exp_q.push_back({1'b1, word});
      sn++;
    end
    next_cycle();
    fcs_in_strobe = 1'b0;
    repeat (4) next_cycle();
  endtask

  // tready picked at the edge and driven just after it
  always @(posedge clk)
  begin
    ready_nxt = drain | (~stall_now & ready_pat[cyc % 1024]);
    cyc = cyc + 1;
    #1;
    m_axis_tready = ready_nxt;
  end

  // stream collector samples mid-cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (rx_pkt_intr === 1'b1)
        intr_count++;
      if (held)
        expect_true(m_axis_tvalid && {m_axis_tlast, m_axis_tdata} === held_data,
                    "tvalid, tlast or tdata changed while waiting for tready");
      if (m_axis_tvalid && m_axis_tready)
      begin
        if (exp_q.size() == 0)
          expect_true(1'b0, "word on the stream when none was expected");
        else
        begin
          exp_word = exp_q.pop_front();
          expect_true({m_axis_tlast, m_axis_tdata} === exp_word,
                      $sformatf("word %0d is %h, expected %h", words,
                                {m_axis_tlast, m_axis_tdata}, exp_word));
          words++;
        end
      end
      held      = m_axis_tvalid && !m_axis_tready;
      held_data = {m_axis_tlast, m_axis_tdata};
    end
  end

  initial
  begin
    #(NUM_ROWS * 200 * CLK_NS);
    $display("timeout: run did not finish within %0d cycles", NUM_ROWS * 200);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    int    row_intr;
    string outcome;
    void'($urandom(41));
    for (int i = 0; i < 32; i++)
      ready_pat[i*32 +: 32] = $urandom;
    // len, rate, tsf, fcs, header valid, tready held low
    tbl[0]  = '{16'd1,   8'h0b, 64'h0000_0000_0001_a5a1, 1'b1, 1'b1, 1'b0};
    tbl[1]  = '{16'd8,   8'h0f, 64'h0000_0000_0002_3c10, 1'b0, 1'b1, 1'b0};
    tbl[2]  = '{16'd13,  8'h0a, 64'h0000_0001_0000_7e22, 1'b1, 1'b1, 1'b0};
    tbl[3]  = '{16'd16,  8'h0e, 64'h0000_0001_0003_4411, 1'b1, 1'b0, 1'b0};
    tbl[4]  = '{16'd16,  8'h0e, 64'h0000_0001_0004_4412, 1'b1, 1'b1, 1'b0};
    tbl[5]  = '{16'd120, 8'h0c, 64'h0000_0002_0000_9001, 1'b1, 1'b1, 1'b0};
    tbl[6]  = '{16'd40,  8'h0d, 64'h0000_0002_0001_b0b0, 1'b1, 1'b1, 1'b1};
    tbl[7]  = '{16'd24,  8'h08, 64'h0000_0002_0002_c1c1, 1'b0, 1'b1, 1'b1};
    tbl[8]  = '{16'd32,  8'h09, 64'h0000_0002_0003_d2d2, 1'b1, 1'b1, 1'b1};
    tbl[9]  = '{16'd16,  8'h0b, 64'h0000_0002_0004_e3e3, 1'b1, 1'b1, 1'b1};
    tbl[10] = '{16'd27,  8'h0f, 64'h0000_0003_0000_f4f4, 1'b1, 1'b1, 1'b0};
    tbl[11] = '{16'd5,   8'h0a, 64'h0000_0003_0001_0505, 1'b0, 1'b1, 1'b0};
    rst_n                   = 1'b0;
    pkt_header_valid_strobe = 1'b0;
    pkt_header_valid        = 1'b0;
    pkt_rate                = '0;
    pkt_len                 = '0;
    tsf_runtime_val         = '0;
    byte_in_strobe          = 1'b0;
    byte_in                 = '0;
    fcs_in_strobe           = 1'b0;
    fcs_ok                  = 1'b0;
    m_axis_tready           = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    expect_true(!m_axis_tvalid && !m_axis_tlast && !rx_pkt_intr, "outputs not idle after reset");
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      // empty the FIFO whenever the tready mode changes
      if (i > 0 && tbl[i].stall != tbl[i-1].stall)
      begin
        stall_now = 1'b0;
        wait_drain();
      end
      stall_now = tbl[i].stall;
      row_intr  = intr_count;
      send_packet(tbl[i], outcome);
      expect_true((intr_count - row_intr) == ((outcome == "queued") ? 1 : 0),
                  $sformatf("row %0d raised %0d interrupts", i, intr_count - row_intr));
      $display("row %0d len %0d: %s, %0d interrupt(s)", i, tbl[i].len, outcome,
               intr_count - row_intr);
    end
    stall_now = 1'b0;
    drain     = 1'b1;
    wait_drain();
    repeat (4) next_cycle();
    expect_true(!m_axis_tvalid, "stream still valid after all expected words");
    expect_true(intr_count == accepted, "interrupt count differs from accepted packets");
    $display("checks %0d, errors %0d, words %0d, interrupts %0d, accepted %0d",
             checks, errors, words, intr_count, accepted);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: design/rx_intf.sv
// next header no sooner than 2 cycles after FCS; packets over 112 bytes never fit and drop
`timescale 1ns/1ps
`include "rx_intf_consts.svh"

module rx_intf
  import rx_intf_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pkt_header_valid_strobe,
  input  logic                      pkt_header_valid,
  input  logic [`RX_RATE_WIDTH-1:0] pkt_rate,
  input  logic [`RX_LEN_WIDTH-1:0]  pkt_len,
  input  logic [`RX_TSF_WIDTH-1:0]  tsf_runtime_val,
  input  logic                      byte_in_strobe,
  input  logic [7:0]                byte_in,
  input  logic                      fcs_in_strobe,
  input  logic                      fcs_ok,
  output logic                      m_axis_tvalid,
  output logic [`RX_WORD_WIDTH-1:0] m_axis_tdata,
  output logic                      m_axis_tlast,
  input  logic                      m_axis_tready,
  output logic                      rx_pkt_intr
);

  // packer outputs
  logic [`RX_WORD_WIDTH-1:0]     packed_word;
  logic                          word_strobe;
  logic                          final_strobe;
  logic [`RX_LEN_WIDTH-1:0]      byte_total;
  logic                          fcs_pass;

  // control outputs
  logic                          meta_load;
  logic                          pack_clear;
  logic                          sn_advance;
  word_sel_t                     word_sel;
  logic                          fifo_wr;

  // into and back from the FIFO
  logic [`RX_WORD_WIDTH-1:0]     queue_word;
  logic                          queue_last;
  logic [`RX_FIFO_CNT_WIDTH-1:0] free_count;

  byte_to_word byte_to_word_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .pack_clear     (pack_clear),
    .byte_in_strobe (byte_in_strobe),
    .byte_in        (byte_in),
    .fcs_in_strobe  (fcs_in_strobe),
    .fcs_ok         (fcs_ok),
    .packed_word    (packed_word),
    .word_strobe    (word_strobe),
    .final_strobe   (final_strobe),
    .byte_total     (byte_total),
    .fcs_pass       (fcs_pass)
  );

  rx_word_assemble rx_word_assemble_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .meta_load       (meta_load),
    .sn_advance      (sn_advance),
    .word_sel        (word_sel),
    .pkt_rate        (pkt_rate),
    .pkt_len         (pkt_len),
    .tsf_runtime_val (tsf_runtime_val),
    .packed_word     (packed_word),
    .byte_total      (byte_total),
    .fcs_pass        (fcs_pass),
    .queue_word      (queue_word),
    .queue_last      (queue_last)
  );

  rx_word_fifo rx_word_fifo_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fifo_wr       (fifo_wr),
    .queue_word    (queue_word),
    .queue_last    (queue_last),
    .m_axis_tready (m_axis_tready),
    .free_count    (free_count),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

  rx_pkt_ctrl rx_pkt_ctrl_i (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .pkt_header_valid_strobe (pkt_header_valid_strobe),
    .pkt_header_valid        (pkt_header_valid),
    .pkt_len                 (pkt_len),
    .free_count              (free_count),
    .word_strobe             (word_strobe),
    .final_strobe            (final_strobe),
    .meta_load               (meta_load),
    .pack_clear              (pack_clear),
    .sn_advance              (sn_advance),
    .word_sel                (word_sel),
    .fifo_wr                 (fifo_wr),
    .rx_pkt_intr             (rx_pkt_intr)
  );

endmodule

// File: design/rx_pkt_ctrl.sv
// headers are taken only in idle or the status cycle; a packet needing more than free room drops
`timescale 1ns/1ps
`include "rx_intf_consts.svh"

module rx_pkt_ctrl
  import rx_intf_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          pkt_header_valid_strobe,
  input  logic                          pkt_header_valid,
  input  logic [`RX_LEN_WIDTH-1:0]      pkt_len,
  input  logic [`RX_FIFO_CNT_WIDTH-1:0] free_count,
  input  logic                          word_strobe,
  input  logic                          final_strobe,
  output logic                          meta_load,
  output logic                          pack_clear,
  output logic                          sn_advance,
  output word_sel_t                     word_sel,
  output logic                          fifo_wr,
  output logic                          rx_pkt_intr
);

  localparam int NEED_W = `RX_LEN_WIDTH + 1;
  localparam logic [NEED_W-1:0] LANE_PAD = NEED_W'(`RX_BYTES_PER_WORD - 1);

  rx_state_t         state;
  rx_state_t         state_nxt;
  logic              hdr_pend;
  logic              hdr_accept;
  logic              fits;
  logic [NEED_W-1:0] need_words;
  logic [NEED_W-1:0] room;

  assign hdr_accept = pkt_header_valid_strobe & pkt_header_valid &
                      ((state == RX_IDLE) | (state == RX_STATUS));

  // header + payload words + status
  assign need_words = ((NEED_W'(pkt_len) + LANE_PAD) / NEED_W'(`RX_BYTES_PER_WORD))
                      + NEED_W'(2);

  // status write of this cycle is not in free_count yet
  assign room = NEED_W'(free_count) - NEED_W'(state == RX_STATUS);
  assign fits = (need_words <= room);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      hdr_pend <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      hdr_pend <= meta_load;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      RX_IDLE, RX_STATUS:
      begin
        if (hdr_accept)
          state_nxt = fits ? RX_PAYLOAD : RX_DROP;
        else
          state_nxt = RX_IDLE;
      end
      RX_PAYLOAD:
        if (final_strobe)
          state_nxt = RX_STATUS;
      // nothing queued, just wait out the packet
      RX_DROP:
        if (final_strobe)
          state_nxt = RX_IDLE;
      default:
        state_nxt = RX_IDLE;
    endcase
  end

  assign meta_load   = hdr_accept & fits;
  assign pack_clear  = hdr_accept;
  assign sn_advance  = (state == RX_STATUS);
  assign rx_pkt_intr = (state == RX_STATUS);

  // header goes in the cycle after admission, before any payload word can exist
  assign fifo_wr = hdr_pend | ((state == RX_PAYLOAD) & word_strobe) | (state == RX_STATUS);

  always_comb
  begin
    if (state == RX_STATUS)
      word_sel = WSEL_STATUS;
    else if (hdr_pend)
      word_sel = WSEL_HEADER;
    else
      word_sel = WSEL_PAYLOAD;
  end

endmodule

// File: design/rx_word_fifo.sv
// writes are never refused; the writer must keep to free_count, depth a power of two
`timescale 1ns/1ps
`include "rx_intf_consts.svh"

module rx_word_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fifo_wr,
  input  logic [`RX_WORD_WIDTH-1:0]    queue_word,
  input  logic                         queue_last,
  input  logic                         m_axis_tready,
  output logic [`RX_FIFO_CNT_WIDTH-1:0] free_count,
  output logic                         m_axis_tvalid,
  output logic [`RX_WORD_WIDTH-1:0]    m_axis_tdata,
  output logic                         m_axis_tlast
);

  localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);
  localparam logic [`RX_FIFO_CNT_WIDTH-1:0] DEPTH_CNT = `RX_FIFO_DEPTH;

  // last flag rides in the top bit of each entry
  logic [`RX_WORD_WIDTH:0]         mem [`RX_FIFO_DEPTH];
  logic [`RX_WORD_WIDTH:0]         head;
  logic [PTR_W-1:0]                wr_ptr;
  logic [PTR_W-1:0]                rd_ptr;
  logic [`RX_FIFO_CNT_WIDTH-1:0]   count;
  logic                            rd_en;

  always_ff @(posedge clk)
  begin
    if (fifo_wr)
      mem[wr_ptr] <= {queue_last, queue_word};
  end

  // pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (fifo_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({fifo_wr, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry drives the stream directly
  assign head          = mem[rd_ptr];
  assign m_axis_tvalid = (count != '0);
  assign m_axis_tdata  = head[`RX_WORD_WIDTH-1:0];
  assign m_axis_tlast  = m_axis_tvalid & head[`RX_WORD_WIDTH];
  assign rd_en         = m_axis_tvalid & m_axis_tready;

  assign free_count = DEPTH_CNT - count;

endmodule

// File: design/rx_word_assemble.sv
// metadata is latched at admission; only the status word carries the last flag
`timescale 1ns/1ps
`include "rx_intf_consts.svh"

module rx_word_assemble
  import rx_intf_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      meta_load,
  input  logic                      sn_advance,
  input  word_sel_t                 word_sel,
  input  logic [`RX_RATE_WIDTH-1:0] pkt_rate,
  input  logic [`RX_LEN_WIDTH-1:0]  pkt_len,
  input  logic [`RX_TSF_WIDTH-1:0]  tsf_runtime_val,
  input  logic [`RX_WORD_WIDTH-1:0] packed_word,
  input  logic [`RX_LEN_WIDTH-1:0]  byte_total,
  input  logic                      fcs_pass,
  output logic [`RX_WORD_WIDTH-1:0] queue_word,
  output logic                      queue_last
);

  logic [`RX_RATE_WIDTH-1:0]    rate_q;
  logic [`RX_LEN_WIDTH-1:0]     len_q;
  logic [`RX_TSF_LOW_WIDTH-1:0] tsf_low_q;
  logic [`RX_SN_WIDTH-1:0]      sn;
  logic [`RX_WORD_WIDTH-1:0]    header_word;
  logic [`RX_WORD_WIDTH-1:0]    status_word;

  // packet metadata, taken with the accepted header
  always_ff @(posedge clk)
  begin
    if (meta_load)
    begin
      rate_q    <= pkt_rate;
      len_q     <= pkt_len;
      tsf_low_q <= tsf_runtime_val[`RX_TSF_LOW_WIDTH-1:0];
    end
  end

  // sequence number, bumped once per queued packet
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sn <= '0;
    else if (sn_advance)
      sn <= sn + 1'b1;
  end

  always_comb
  begin
    header_word = '0;
    header_word[`RX_HDR_LEN_LSB +: `RX_LEN_WIDTH]      = len_q;
    header_word[`RX_HDR_RATE_LSB +: `RX_RATE_WIDTH]    = rate_q;
    header_word[`RX_HDR_SN_LSB +: `RX_SN_WIDTH]        = sn;
    header_word[`RX_HDR_TSF_LSB +: `RX_TSF_LOW_WIDTH]  = tsf_low_q;
    status_word = '0;
    status_word[`RX_STS_FCS_BIT]                       = fcs_pass;
    status_word[`RX_STS_CNT_LSB +: `RX_LEN_WIDTH]      = byte_total;
  end

  always_comb
  begin
    queue_word = packed_word;
    queue_last = 1'b0;
    case (word_sel)
      WSEL_HEADER:  queue_word = header_word;
      WSEL_PAYLOAD: queue_word = packed_word;
      WSEL_STATUS:
      begin
        queue_word = status_word;
        queue_last = 1'b1;
      end
      default:      queue_word = packed_word;
    endcase
  end

endmodule

// File: design/byte_to_word.sv
// at most one byte per cycle; the FCS strobe must come after the last byte, not with it
`timescale 1ns/1ps
`include "rx_intf_consts.svh"

module byte_to_word (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pack_clear,
  input  logic                      byte_in_strobe,
  input  logic [7:0]                byte_in,
  input  logic                      fcs_in_strobe,
  input  logic                      fcs_ok,
  output logic [`RX_WORD_WIDTH-1:0] packed_word,
  output logic                      word_strobe,
  output logic                      final_strobe,
  output logic [`RX_LEN_WIDTH-1:0]  byte_total,
  output logic                      fcs_pass
);

  localparam int BYTE_W = `RX_WORD_WIDTH / `RX_BYTES_PER_WORD;
  localparam int LANE_W = $clog2(`RX_BYTES_PER_WORD);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`RX_BYTES_PER_WORD - 1);

  logic [LANE_W-1:0]         lane;
  logic [`RX_WORD_WIDTH-1:0] word_reg;
  logic [`RX_WORD_WIDTH-1:0] word_with_byte;

  // byte 0 lands in the low lane
  always_comb
  begin
    word_with_byte = word_reg;
    word_with_byte[lane*BYTE_W +: BYTE_W] = byte_in;
  end

  // lane counter, byte count and strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lane         <= '0;
      byte_total   <= '0;
      word_strobe  <= 1'b0;
      final_strobe <= 1'b0;
    end
    else
    begin
      word_strobe  <= 1'b0;
      final_strobe <= fcs_in_strobe;
      if (pack_clear)
      begin
        lane       <= '0;
        byte_total <= '0;
      end
      else if (byte_in_strobe)
      begin
        byte_total  <= byte_total + 1'b1;
        lane        <= (lane == LAST_LANE) ? '0 : lane + 1'b1;
        word_strobe <= (lane == LAST_LANE);
      end
      else if (fcs_in_strobe)
      begin
        // flush whatever partial word is left
        lane        <= '0;
        word_strobe <= (lane != '0);
      end
    end
  end

  // word register is cleared after each emit, so partial words come out zero-padded
  always_ff @(posedge clk)
  begin
    if (pack_clear)
      word_reg <= '0;
    else if (byte_in_strobe)
    begin
      if (lane == LAST_LANE)
      begin
        packed_word <= word_with_byte;
        word_reg    <= '0;
      end
      else
        word_reg <= word_with_byte;
    end
    else if (fcs_in_strobe)
    begin
      packed_word <= word_reg;
      word_reg    <= '0;
    end
    if (fcs_in_strobe)
      fcs_pass <= fcs_ok;
  end

endmodule

// File: design/rx_intf_pkg.sv
// encodings are 2 bits wide; the fourth word_sel code is unused and falls back to payload
package rx_intf_pkg;

  // packet control states
  typedef enum logic [1:0]
  {
    // waiting for a header
    RX_IDLE    = 2'd0,
    // admitted, queueing payload words
    RX_PAYLOAD = 2'd1,
    // no room, discarding until the FCS
    RX_DROP    = 2'd2,
    // one cycle, status word and interrupt
    RX_STATUS  = 2'd3
  } rx_state_t;

  // picks which word goes into the FIFO
  typedef enum logic [1:0]
  {
    WSEL_HEADER  = 2'd0,
    WSEL_PAYLOAD = 2'd1,
    WSEL_STATUS  = 2'd2
  } word_sel_t;

endpackage

// File: design/rx_intf_consts.svh
// 64-bit stream words and a 16-word FIFO; the FIFO depth must stay a power of two
`ifndef RX_INTF_CONSTS_SVH
`define RX_INTF_CONSTS_SVH

// stream and FIFO geometry
`define RX_WORD_WIDTH      64
`define RX_BYTES_PER_WORD  8
`define RX_FIFO_DEPTH      16
`define RX_FIFO_CNT_WIDTH  5

// decoder field widths
`define RX_LEN_WIDTH       16
`define RX_RATE_WIDTH      8
`define RX_SN_WIDTH        16
`define RX_TSF_WIDTH       64
`define RX_TSF_LOW_WIDTH   16

// header word, lsb of each field
`define RX_HDR_LEN_LSB     0
`define RX_HDR_RATE_LSB    16
`define RX_HDR_SN_LSB      32
`define RX_HDR_TSF_LSB     48

// status word
`define RX_STS_FCS_BIT     0
`define RX_STS_CNT_LSB     16

`endif
